/* filelist.f */
+incdir+rtl
rtl/harness_pkg.sv
rtl/axil_front.sv
rtl/mem_bank.sv
rtl/resp_collect.sv
rtl/mem_harness_top.sv
sim/tb_clk_gen.sv
sim/tb_checker.sv
sim/tb_mem_harness.sv

/* Bender.yml */
package:
  name: mem_harness

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/harness_pkg.sv
      - rtl/axil_front.sv
      - rtl/mem_bank.sv
      - rtl/resp_collect.sv
      - rtl/mem_harness_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_checker.sv
      - sim/tb_mem_harness.sv

/* sim/tb_mem_harness.sv */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defs.svh"

module tb_mem_harness;

  import harness_pkg::*;

  localparam int ClkPeriod = 8;
  localparam int MaxStall = 8;
  localparam int NumTrans = 130;
  localparam int WatchdogCycles = NumTrans * (`HARNESS_LATENCY + MaxStall + 4) + 200;
  localparam addr_t Base = `HARNESS_BANK_BASE;
  localparam addr_t Stride = `HARNESS_BANK_STRIDE;

  logic      clk;
  logic      rst_n;
  axil_req_t req;
  axil_rsp_t rsp;
  resp_e     exp_resp;
  data_t     exp_data;

  data_t       ref_mem [int unsigned];
  int          seed;
  bit          bp_en;
  bit          last_wr;
  int          stall;
  addr_t       pool [8];
  addr_t       bad [3];
  addr_t       addr;
  int          sel;
  int          kind;
  data_t       data;
  strb_t       strb;

  tb_clk_gen #(.PeriodNs(ClkPeriod), .ResetCycles(4)) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mem_harness_top u_mem_harness_top (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .axil_req_i (req),
    .axil_rsp_o (rsp)
  );

  tb_checker u_checker (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .req_i      (req),
    .rsp_i      (rsp),
    .exp_resp_i (exp_resp),
    .exp_data_i (exp_data)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  // Mapped when the address lies in the first 1 KiB above some bank base
  function automatic bit in_map(input addr_t a);
    addr_t lo;
    bit    found;
    found = 1'b0;
    for (int b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      lo = Base + b * Stride;
      if (a >= lo && (a - lo) < `HARNESS_BANK_WORDS * 4) found = 1'b1;
    end
    return found;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t s);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  // Expected {resp, read data} for one access
  function automatic logic [33:0] ref_access(input addr_t a, input bit we, input data_t wdata,
                                             input strb_t s);
    if (!in_map(a)) return {DECERR, 32'h0};
    if (we) return {OKAY, 32'h0};
    return {OKAY, ref_mem[a[31:2]]};
  endfunction

  task automatic record_accept(input bit we, input addr_t a, input data_t wdata, input strb_t s);
    logic [33:0] res;
    res = ref_access(a, we, wdata, s);
    exp_resp = resp_e'(res[33:32]);
    exp_data = res[31:0];
    if (we && in_map(a)) begin
      ref_mem[a[31:2]] = merge_bytes(ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : '0, wdata, s);
    end
    last_wr = we;
  endtask

  // ------------------------------
  // Stimulus tasks
  // ------------------------------
  task automatic wait_resp();
    do @(posedge clk);
    while (!((rsp.b_valid && req.b_ready) || (rsp.r_valid && req.r_ready)));
    #1;
  endtask

  task automatic single(input bit we, input addr_t a, input data_t wdata, input strb_t s);
    if (we) begin
      req.aw_valid = 1'b1;
      req.aw_addr  = a;
      req.w_valid  = 1'b1;
      req.w_data   = wdata;
      req.w_strb   = s;
    end else begin
      req.ar_valid = 1'b1;
      req.ar_addr  = a;
    end
    do @(posedge clk);
    while (we ? !(rsp.aw_ready && rsp.w_ready) : !rsp.ar_ready);
    record_accept(we, a, wdata, s);
    #1;
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.ar_valid = 1'b0;
    wait_resp();
  endtask

  // Write and read offered together
  task automatic pair(input addr_t wa, input data_t wdata, input strb_t s, input addr_t ra);
    bit wdone;
    bit rdone;
    bit first_wr;
    bit n_acc;
    wdone    = 1'b0;
    rdone    = 1'b0;
    n_acc    = 1'b0;
    first_wr = !last_wr;
    req.aw_valid = 1'b1;
    req.aw_addr  = wa;
    req.w_valid  = 1'b1;
    req.w_data   = wdata;
    req.w_strb   = s;
    req.ar_valid = 1'b1;
    req.ar_addr  = ra;
    while (!(wdone && rdone)) begin
      @(posedge clk);
      if (!wdone && rsp.aw_ready && rsp.w_ready) begin
        if (!n_acc) u_checker.check_value("first accepted is write", first_wr, 1);
        record_accept(1'b1, wa, wdata, s);
        wdone = 1'b1;
        n_acc = 1'b1;
      end else if (!rdone && rsp.ar_ready) begin
        if (!n_acc) u_checker.check_value("first accepted is write", first_wr, 0);
        record_accept(1'b0, ra, '0, '0);
        rdone = 1'b1;
        n_acc = 1'b1;
      end
      #1;
      if (wdone) begin
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
      end
      if (rdone) req.ar_valid = 1'b0;
    end
    wait_resp();
  endtask

  // Random back-pressure on B and R
  always @(posedge clk) begin
    #1;
    if (!bp_en) begin
      req.b_ready = 1'b1;
      req.r_ready = 1'b1;
    end else if (stall > 0) begin
      stall--;
      req.b_ready = 1'b0;
      req.r_ready = 1'b0;
    end else if ({$random(seed)} % 3 == 0) begin
      stall = {$random(seed)} % MaxStall;
      req.b_ready = 1'b0;
      req.r_ready = 1'b0;
    end else begin
      req.b_ready = 1'b1;
      req.r_ready = 1'b1;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    seed     = 32'h6720_23af;
    req      = '0;
    req.b_ready = 1'b1;
    req.r_ready = 1'b1;
    bp_en    = 1'b0;
    stall    = 0;
    last_wr  = 1'b0;
    exp_resp = OKAY;
    exp_data = '0;
    for (int i = 0; i < 8; i++) begin
      pool[i] = Base + (i % 4) * Stride + ((i < 4) ? 32'h0c : 32'h320);
    end
    bad[0] = Base + 32'h0400;
    bad[1] = Base - 32'h4;
    bad[2] = Base + `HARNESS_NUM_BANKS * Stride;

    wait (rst_n);
    @(posedge clk);
    #1;
    u_checker.check_value("aw_ready", 1, rsp.aw_ready);
    u_checker.check_value("w_ready", 1, rsp.w_ready);
    u_checker.check_value("ar_ready", 1, rsp.ar_ready);
    u_checker.check_value("b_valid", 0, rsp.b_valid);
    u_checker.check_value("r_valid", 0, rsp.r_valid);
    u_checker.end_test("reset state");

    for (int b = 0; b < 4; b++) begin
      single(1'b1, Base + b * Stride + 32'h40, 32'hc0de_0000 | b, 4'hf);
      single(1'b0, Base + b * Stride + 32'h40, '0, '0);
    end
    u_checker.end_test("write then read per bank");

    single(1'b1, Base + Stride + 32'h28, 32'h1122_3344, 4'hf);
    single(1'b1, Base + Stride + 32'h28, 32'haabb_ccdd, 4'b0001);
    single(1'b0, Base + Stride + 32'h28, '0, '0);
    single(1'b1, Base + Stride + 32'h28, 32'h5566_7788, 4'b1010);
    single(1'b0, Base + Stride + 32'h28, '0, '0);
    single(1'b1, Base + 3 * Stride + 32'h3fc, 32'hdead_beef, 4'hf);
    single(1'b1, Base + 3 * Stride + 32'h3fc, 32'h0123_4567, 4'b0110);
    single(1'b0, Base + 3 * Stride + 32'h3fc, '0, '0);
    u_checker.end_test("partial strobes");

    // Gap address aliases word 0 of bank 0 in its low bits
    single(1'b1, Base, 32'h0bad_f00d, 4'hf);
    for (int i = 0; i < 3; i++) begin
      single(1'b1, bad[i], 32'hffff_ffff, 4'hf);
      single(1'b0, bad[i], '0, '0);
    end
    single(1'b0, Base, '0, '0);
    u_checker.end_test("unmapped addresses");

    bp_en = 1'b1;
    for (int i = 0; i < 8; i++) single(1'b1, pool[i], 32'h1000_0000 + i, 4'hf);
    for (int n = 0; n < 40; n++) begin
      kind = {$random(seed)} % 3;
      sel  = {$random(seed)} % 11;
      addr = (sel < 8) ? pool[sel] : bad[sel-8];
      data = $random(seed);
      strb = $random(seed);
      case (kind)
        0:       single(1'b1, addr, data, strb);
        1:       single(1'b0, addr, '0, '0);
        default: pair(addr, data, strb, pool[{$random(seed)} % 8]);
      endcase
    end
    bp_en = 1'b0;
    u_checker.end_test("random mix with back-pressure");

    single(1'b1, pool[0], 32'h7777_0000, 4'hf);
    single(1'b0, pool[0], '0, '0);
    single(1'b0, bad[0], '0, '0);
    single(1'b1, bad[2], 32'h0, 4'hf);
    pair(pool[1], 32'h8888_1111, 4'hf, pool[1]);
    pair(pool[2], 32'h9999_2222, 4'h3, pool[5]);
    pair(bad[1], 32'h0, 4'hf, pool[2]);
    u_checker.end_test("latency and alternation");

    u_checker.report_summary();
    if (u_checker.error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding", WatchdogCycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defs.svh"

module tb_checker (
  input wire logic                   clk_i,
  input wire logic                   rst_ni,
  input wire harness_pkg::axil_req_t req_i,
  input wire harness_pkg::axil_rsp_t rsp_i,
  input wire harness_pkg::resp_e     exp_resp_i,
  input wire harness_pkg::data_t     exp_data_i
);

  import harness_pkg::*;

  int error_count = 0;
  int test_count = 0;
  int xfer_count = 0;
  int test_err_base = 0;

  bit        busy = 1'b0;
  bit        is_wr;
  bit        seen;
  int        cyc;
  axil_rsp_t prev;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      error_count++;
      $display("Error: %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("At %0t: %s", $time, what);
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %0d %s: %s, %0d errors", test_count, name,
             (error_count == test_err_base) ? "ok" : "FAIL", error_count - test_err_base);
    test_err_base = error_count;
  endtask

  task automatic report_summary();
    $display("Summary: %0d tests, %0d transfers, %0d errors", test_count, xfer_count,
             error_count);
  endtask

  // ------------------------------
  // Bus monitor
  // ------------------------------
  always @(posedge clk_i) begin : monitor
    logic wr_acc;
    logic rd_acc;
    logic valid;
    logic ready;
    wr_acc = req_i.aw_valid && rsp_i.aw_ready && req_i.w_valid && rsp_i.w_ready;
    rd_acc = req_i.ar_valid && rsp_i.ar_ready;
    if (rst_ni) begin
      if (busy) begin
        cyc++;
        valid = is_wr ? rsp_i.b_valid : rsp_i.r_valid;
        ready = is_wr ? req_i.b_ready : req_i.r_ready;
        if (rsp_i.aw_ready || rsp_i.w_ready || rsp_i.ar_ready) begin
          report_failure("a ready is high while a transaction is in flight");
        end
        if (wr_acc || rd_acc) begin
          report_failure("a new request was accepted while one is in flight");
        end
        if (is_wr ? rsp_i.r_valid : rsp_i.b_valid) begin
          report_failure("response appeared on the wrong channel");
        end
        if (valid && !seen) begin
          seen = 1'b1;
          if (cyc - 1 != `HARNESS_LATENCY) begin
            report_failure($sformatf("response came %0d cycles after acceptance", cyc - 1));
          end
        end else if (seen) begin
          // Held response must not move under back-pressure
          if (!valid) begin
            report_failure("response valid dropped before the transfer");
          end else if (is_wr) begin
            check_value("b_resp (held)", prev.b_resp, rsp_i.b_resp);
          end else begin
            check_value("r_data (held)", prev.r_data, rsp_i.r_data);
            check_value("r_resp (held)", prev.r_resp, rsp_i.r_resp);
          end
        end
        prev = rsp_i;
        if (valid && ready) begin
          if (is_wr) begin
            check_value("b_resp", exp_resp_i, rsp_i.b_resp);
          end else begin
            check_value("r_resp", exp_resp_i, rsp_i.r_resp);
            check_value("r_data", exp_data_i, rsp_i.r_data);
          end
          xfer_count++;
          busy = 1'b0;
        end
      end else begin
        if (rsp_i.b_valid || rsp_i.r_valid) begin
          report_failure("response valid without an accepted request");
        end
        if (wr_acc && rd_acc) begin
          report_failure("write and read were accepted in the same cycle");
        end
        if (wr_acc || rd_acc) begin
          busy  = 1'b1;
          is_wr = wr_acc;
          cyc   = 0;
          seen  = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PeriodNs   = 8.0,
  parameter int  ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Release shortly after an edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* rtl/mem_harness_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defs.svh"

module mem_harness_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire harness_pkg::axil_req_t axil_req_i,
  output harness_pkg::axil_rsp_t      axil_rsp_o
);

  import harness_pkg::*;

  mem_req_t                         mem_req;
  bank_sel_t                        bank_sel;
  mem_rsp_t [`HARNESS_NUM_BANKS-1:0] bank_rsp;
  col_rsp_t                         col_rsp;
  logic                             take;

  // ------------------------------
  // Front end
  // ------------------------------
  axil_front u_axil_front (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .col_rsp_i  (col_rsp),
    .mem_req_o  (mem_req),
    .bank_sel_o (bank_sel),
    .take_o     (take)
  );

  // ------------------------------
  // Bank array
  // ------------------------------
  // Request is broadcast, select picks the bank
  for (genvar i = 0; i < `HARNESS_NUM_BANKS; i++) begin : g_bank
    mem_bank u_mem_bank (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req_i  (mem_req),
      .sel_i  (bank_sel[i]),
      .rsp_o  (bank_rsp[i])
    );
  end

  // ------------------------------
  // Response path
  // ------------------------------
  resp_collect u_resp_collect (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (mem_req.valid),
    .sel_i      (bank_sel),
    .bank_rsp_i (bank_rsp),
    .take_i     (take),
    .col_rsp_o  (col_rsp)
  );

endmodule

`default_nettype wire

/* rtl/resp_collect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defs.svh"

module resp_collect (
  input  wire logic                                            clk_i,
  input  wire logic                                            rst_ni,
  input  wire logic                                            issue_i,
  input  wire harness_pkg::bank_sel_t                          sel_i,
  input  wire harness_pkg::mem_rsp_t [`HARNESS_NUM_BANKS-1:0]  bank_rsp_i,
  input  wire logic                                            take_i,
  output harness_pkg::col_rsp_t                                col_rsp_o
);

  import harness_pkg::*;

  logic [`HARNESS_NUM_BANKS-1:0] bank_vld;
  data_t                         hit_data;
  logic                          dec_pend_q;
  logic                          valid_q;
  data_t                         rdata_q;
  resp_e                         resp_q;

  // One-hot merge of the bank answers
  always_comb begin
    hit_data = '0;
    for (int i = 0; i < `HARNESS_NUM_BANKS; i++) begin
      bank_vld[i] = bank_rsp_i[i].valid;
      if (bank_rsp_i[i].valid) begin
        hit_data = hit_data | bank_rsp_i[i].rdata;
      end
    end
  end

  // ------------------------------
  // Control
  // ------------------------------
  // Unmapped issue waits one cycle so it lines up with a bank answer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_pend_q <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      dec_pend_q <= issue_i && (sel_i == '0);
      if (take_i) begin
        valid_q <= 1'b0;
      end else if ((|bank_vld) || dec_pend_q) begin
        valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (|bank_vld) begin
      rdata_q <= hit_data;
      resp_q  <= OKAY;
    end else if (dec_pend_q) begin
      rdata_q <= '0;
      resp_q  <= DECERR;
    end
  end

  assign col_rsp_o.valid = valid_q;
  assign col_rsp_o.rdata = rdata_q;
  assign col_rsp_o.resp  = resp_q;

  a_single_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(bank_vld));

  a_no_rsp_while_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    col_rsp_o.valid |-> !(|bank_vld));

endmodule

`default_nettype wire

/* rtl/mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defs.svh"

module mem_bank (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire harness_pkg::mem_req_t req_i,
  input  wire logic                  sel_i,
  output harness_pkg::mem_rsp_t      rsp_o
);

  import harness_pkg::*;

  localparam int unsigned NumBytes = `HARNESS_DATA_W / 8;

  data_t mem_q [`HARNESS_BANK_WORDS];
  data_t rdata_q;
  logic  valid_q;
  logic  hit;

  assign hit = req_i.valid && sel_i;

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (hit) begin
      if (req_i.we) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (req_i.strb[b]) begin
            mem_q[req_i.idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[req_i.idx];
      end
    end
  end

  // Writes answer too but carry no data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= hit;
    end
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.rdata = rdata_q;

  a_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hit |=> rsp_o.valid ##1 !rsp_o.valid);

endmodule

`default_nettype wire

/* rtl/axil_front.sv */
`timescale 1ns/1ps
`default_nettype none

`include "harness_defs.svh"

module axil_front (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire harness_pkg::axil_req_t axil_req_i,
  output harness_pkg::axil_rsp_t      axil_rsp_o,
  input  wire harness_pkg::col_rsp_t  col_rsp_i,
  output harness_pkg::mem_req_t       mem_req_o,
  output harness_pkg::bank_sel_t      bank_sel_o,
  output logic                        take_o
);

  import harness_pkg::*;

  localparam addr_t Base = `HARNESS_BANK_BASE;
  localparam addr_t Stride = `HARNESS_BANK_STRIDE;
  localparam addr_t MapBytes = addr_t'(`HARNESS_NUM_BANKS * `HARNESS_BANK_STRIDE);
  localparam addr_t BankBytes = addr_t'(`HARNESS_BANK_WORDS * (`HARNESS_DATA_W / 8));
  localparam int unsigned ByteOffW = $clog2(`HARNESS_DATA_W / 8);

  front_state_e state_q, state_d;
  logic         last_wr_q;
  logic         req_vld_q;
  logic         is_wr_q;
  addr_t        addr_q;
  data_t        wdata_q;
  strb_t        strb_q;
  resp_e        resp_q;
  data_t        rdata_q;

  logic  wr_pend;
  logic  pick_wr;
  logic  pick_rd;
  logic  in_map;
  logic  rsp_done;
  addr_t offset;

  // ------------------------------
  // Arbitration
  // ------------------------------
  assign wr_pend = axil_req_i.aw_valid && axil_req_i.w_valid;
  // Alternate when both kinds wait
  assign pick_wr = wr_pend && (!axil_req_i.ar_valid || !last_wr_q);
  assign pick_rd = axil_req_i.ar_valid && (!wr_pend || last_wr_q);

  // AW and W only move together
  assign axil_rsp_o.aw_ready = (state_q == IDLE) && !pick_rd &&
                               (axil_req_i.aw_valid == axil_req_i.w_valid);
  assign axil_rsp_o.w_ready  = axil_rsp_o.aw_ready;
  assign axil_rsp_o.ar_ready = (state_q == IDLE) && !pick_wr;

  assign rsp_done = (state_q == RESP) &&
                    (is_wr_q ? axil_req_i.b_ready : axil_req_i.r_ready);
  assign take_o = (state_q == WAIT) && col_rsp_i.valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (pick_wr || pick_rd) state_d = ISSUE;
      ISSUE:   state_d = WAIT;
      WAIT:    if (col_rsp_i.valid) state_d = RESP;
      RESP:    if (rsp_done) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      last_wr_q <= 1'b0;
      req_vld_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      req_vld_q <= (state_q == ISSUE);
      if (state_q == IDLE && (pick_wr || pick_rd)) begin
        last_wr_q <= pick_wr;
      end
    end
  end

  // Request and result payload
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && (pick_wr || pick_rd)) begin
      is_wr_q <= pick_wr;
      addr_q  <= pick_wr ? axil_req_i.aw_addr : axil_req_i.ar_addr;
      wdata_q <= axil_req_i.w_data;
      strb_q  <= axil_req_i.w_strb;
    end
    if (take_o) begin
      resp_q  <= col_rsp_i.resp;
      rdata_q <= col_rsp_i.rdata;
    end
  end

  // ------------------------------
  // Address decode
  // ------------------------------
  assign offset = addr_q - Base;
  // Below base, past the last bank or inside a stride gap
  assign in_map = (addr_q >= Base) && (offset < MapBytes) && ((offset % Stride) < BankBytes);

  always_comb begin
    for (int i = 0; i < `HARNESS_NUM_BANKS; i++) begin
      bank_sel_o[i] = in_map && ((offset / Stride) == addr_t'(i));
    end
  end

  assign mem_req_o.valid = req_vld_q;
  assign mem_req_o.we    = is_wr_q;
  assign mem_req_o.idx   = addr_q[ByteOffW +: $bits(word_idx_t)];
  assign mem_req_o.wdata = wdata_q;
  assign mem_req_o.strb  = strb_q;

  // ------------------------------
  // B and R channels
  // ------------------------------
  assign axil_rsp_o.b_valid = (state_q == RESP) && is_wr_q;
  assign axil_rsp_o.b_resp  = resp_q;
  assign axil_rsp_o.r_valid = (state_q == RESP) && !is_wr_q;
  assign axil_rsp_o.r_data  = rdata_q;
  assign axil_rsp_o.r_resp  = resp_q;

  a_issue_from_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.valid |-> (state_q == WAIT) && !col_rsp_i.valid);

  a_sel_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.valid |-> $onehot0(bank_sel_o) && ((|bank_sel_o) == in_map));

endmodule

`default_nettype wire

/* rtl/harness_pkg.sv */
`default_nettype none

`include "harness_defs.svh"

package harness_pkg;

  typedef logic [`HARNESS_ADDR_W-1:0] addr_t;
  typedef logic [`HARNESS_DATA_W-1:0] data_t;
  typedef logic [`HARNESS_DATA_W/8-1:0] strb_t;
  typedef logic [$clog2(`HARNESS_BANK_WORDS)-1:0] word_idx_t;
  typedef logic [`HARNESS_NUM_BANKS-1:0] bank_sel_t;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    RESP
  } front_state_e;

  // ------------------------------
  // AXI4-Lite
  // ------------------------------
  typedef struct packed {
    logic  aw_valid;
    addr_t aw_addr;
    logic  w_valid;
    data_t w_data;
    strb_t w_strb;
    logic  b_ready;
    logic  ar_valid;
    addr_t ar_addr;
    logic  r_ready;
  } axil_req_t;

  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    logic  ar_ready;
    logic  b_valid;
    resp_e b_resp;
    logic  r_valid;
    data_t r_data;
    resp_e r_resp;
  } axil_rsp_t;

  // ------------------------------
  // Bank side
  // ------------------------------
  typedef struct packed {
    logic      valid;
    logic      we;
    word_idx_t idx;
    data_t     wdata;
    strb_t     strb;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic  valid;
    data_t rdata;
    resp_e resp;
  } col_rsp_t;

endpackage

`default_nettype wire

/* rtl/harness_defs.svh */
`ifndef HARNESS_DEFS_SVH
`define HARNESS_DEFS_SVH

// ------------------------------
// Bus widths
// ------------------------------
`define HARNESS_ADDR_W 32
`define HARNESS_DATA_W 32

// ------------------------------
// Bank array
// ------------------------------
`define HARNESS_NUM_BANKS 4
`define HARNESS_BANK_WORDS 256

// Bank 0 base, later banks follow at a fixed stride
`define HARNESS_BANK_BASE 32'h8000_0000
`define HARNESS_BANK_STRIDE 32'h0001_0000

// ------------------------------
// Timing
// ------------------------------
// Cycles from the accepting edge to bvalid or rvalid
`define HARNESS_LATENCY 4

`endif
